//--- hw/pw_pkg.sv
`default_nettype none

package pw_pkg;

   typedef logic [7:0] byte_t;   // one usb data byte
   typedef logic [7:0] addr_t;   // register address

   localparam int PATTERN_BYTES = 4;
   typedef logic [PATTERN_BYTES*8-1:0] pattern_t;  // newest byte in [7:0]

   typedef logic [15:0] count_t;  // delay, width, capture length
   typedef logic [7:0]  stamp_t;  // saturates at 255
   typedef logic [15:0] entry_t;  // {stamp, data}

   localparam int FIFO_DEPTH = 16;
   typedef logic [3:0] fifo_ptr_t;

   typedef enum logic [1:0] {LS = 2'd0, FS = 2'd1, HS = 2'd2, AUTO = 2'd3} speed_t;

   typedef enum logic [1:0] {IDLE, ARMED, CAPTURE} ctrl_state_t;

   //////////////////////////////
   // register map
   localparam addr_t ADDR_ARM     = 8'h00;
   localparam addr_t ADDR_SPEED   = 8'h01;
   localparam addr_t ADDR_PATTERN = 8'h02;  // 0x02..0x05, byte 0 first
   localparam addr_t ADDR_MASK    = 8'h06;  // 0x06..0x09
   localparam addr_t ADDR_DELAY   = 8'h0A;  // low byte, high at +1
   localparam addr_t ADDR_WIDTH   = 8'h0C;
   localparam addr_t ADDR_LEN     = 8'h0E;
   localparam addr_t ADDR_FIFO    = 8'h10;

endpackage

`default_nettype wire

//--- hw/pw_regs.sv
`default_nettype none
`timescale 1ns/1ps

module pw_regs (
   input  wire                   fe_clk,
   input  wire                   arst_n_i,
   input  wire pw_pkg::addr_t    reg_addr_i,
   input  wire pw_pkg::byte_t    reg_wdata_i,
   input  wire                   reg_write_i,
   input  wire                   reg_read_i,
   input  wire pw_pkg::entry_t   fifo_head_i,
   input  wire                   fifo_empty_i,
   output pw_pkg::entry_t        reg_rdata_o,
   output pw_pkg::pattern_t      pattern_o,
   output pw_pkg::pattern_t      mask_o,
   output pw_pkg::count_t        delay_o,
   output pw_pkg::count_t        width_o,
   output pw_pkg::count_t        capture_len_o,
   output pw_pkg::speed_t        speed_o,
   output logic                  arm_req_o,
   output logic                  fifo_pop_o
);
   import pw_pkg::*;

   logic fifo_rd;

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pattern_o     <= '0;
         mask_o        <= '0;
         delay_o       <= '0;
         width_o       <= '0;
         capture_len_o <= '0;
         speed_o       <= LS;
      end else if (reg_write_i) begin
         // pattern and mask are byte addressed, byte 0 first
         for (int i = 0; i < PATTERN_BYTES; i++) begin
            if (reg_addr_i == ADDR_PATTERN + addr_t'(i))
               pattern_o[8*i +: 8] <= reg_wdata_i;
            if (reg_addr_i == ADDR_MASK + addr_t'(i))
               mask_o[8*i +: 8] <= reg_wdata_i;
         end
         case (reg_addr_i)
            ADDR_SPEED:       speed_o            <= speed_t'(reg_wdata_i[1:0]);
            ADDR_DELAY:       delay_o[7:0]       <= reg_wdata_i;
            ADDR_DELAY + 1:   delay_o[15:8]      <= reg_wdata_i;
            ADDR_WIDTH:       width_o[7:0]       <= reg_wdata_i;
            ADDR_WIDTH + 1:   width_o[15:8]      <= reg_wdata_i;
            ADDR_LEN:         capture_len_o[7:0] <= reg_wdata_i;
            ADDR_LEN + 1:     capture_len_o[15:8] <= reg_wdata_i;
            default: ;
         endcase
      end
   end

   // arm is a strobe, not a stored bit
   assign arm_req_o = reg_write_i && (reg_addr_i == ADDR_ARM) && reg_wdata_i[0];

   // head shows in the read cycle, popped on its edge
   assign fifo_rd     = reg_read_i && (reg_addr_i == ADDR_FIFO) && !fifo_empty_i;
   assign fifo_pop_o  = fifo_rd;
   assign reg_rdata_o = fifo_rd ? fifo_head_i : '0;

endmodule

`default_nettype wire

//--- hw/capture_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module capture_ctrl (
   input  wire                   fe_clk,
   input  wire                   arst_n_i,
   input  wire                   arm_req_i,
   input  wire                   match_i,
   input  wire                   fe_rxvalid_i,
   input  wire pw_pkg::count_t   capture_len_i,
   output logic                  fire_o,
   output logic                  fifo_write_o,
   output logic                  armed_o,
   output logic                  capturing_o
);
   import pw_pkg::*;

   ctrl_state_t state_q;
   count_t      count_q;   // bytes recorded so far

   // a fresh arm wins over a match in the same cycle
   assign fire_o       = (state_q == ARMED) && match_i && !arm_req_i;
   assign fifo_write_o = (state_q == CAPTURE) && fe_rxvalid_i && (count_q < capture_len_i);
   assign armed_o      = (state_q == ARMED);
   assign capturing_o  = (state_q == CAPTURE);

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
         count_q <= '0;
      end else if (arm_req_i) begin
         state_q <= ARMED;
         count_q <= '0;
      end else begin
         case (state_q)
            ARMED: begin
               if (fire_o) state_q <= CAPTURE;
            end
            CAPTURE: begin
               if (capture_len_i == '0) begin
                  state_q <= IDLE;  // nothing to record
               end else if (fifo_write_o) begin
                  count_q <= count_q + 16'd1;
                  if (count_q + 16'd1 == capture_len_i) state_q <= IDLE;
               end
            end
            default: ;  // idle waits for arm
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/pattern_matcher.sv
`default_nettype none
`timescale 1ns/1ps

module pattern_matcher (
   input  wire                   fe_clk,
   input  wire                   arst_n_i,
   input  wire pw_pkg::byte_t    fe_data_i,
   input  wire                   fe_rxvalid_i,
   input  wire pw_pkg::pattern_t pattern_i,
   input  wire pw_pkg::pattern_t mask_i,
   output logic                  match_o
);
   import pw_pkg::*;

   pattern_t window_q;
   pattern_t window_next;
   logic     hit;

   // oldest byte falls off the top
   assign window_next = {window_q[(PATTERN_BYTES-1)*8-1:0], fe_data_i};

   // compare only the bits set in the mask
   assign hit = ((window_next ^ pattern_i) & mask_i) == '0;

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         window_q <= '0;
         match_o  <= 1'b0;
      end else begin
         match_o <= 1'b0;          // one cycle only
         if (fe_rxvalid_i) begin
            window_q <= window_next;
            match_o  <= hit;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/trigger_pulse.sv
`default_nettype none
`timescale 1ns/1ps

module trigger_pulse (
   input  wire                   fe_clk,
   input  wire                   arst_n_i,
   input  wire                   fire_i,
   input  wire pw_pkg::count_t   delay_i,
   input  wire pw_pkg::count_t   width_i,
   output logic                  trig_o
);
   import pw_pkg::*;

   logic   waiting_q;   // delay phase
   count_t cnt_q;       // cycles left in current phase

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         waiting_q <= 1'b0;
         trig_o    <= 1'b0;
         cnt_q     <= '0;
      end else if (fire_i) begin
         if (delay_i == '0) begin
            trig_o <= (width_i != '0);  // straight into the pulse
            cnt_q  <= width_i;
         end else begin
            waiting_q <= 1'b1;
            cnt_q     <= delay_i;
         end
      end else if (waiting_q) begin
         if (cnt_q == 16'd1) begin
            waiting_q <= 1'b0;
            trig_o    <= (width_i != '0);
            cnt_q     <= width_i;
         end else begin
            cnt_q <= cnt_q - 16'd1;
         end
      end else if (trig_o) begin
         if (cnt_q == 16'd1) trig_o <= 1'b0;  // last high cycle
         cnt_q <= cnt_q - 16'd1;
      end
   end

endmodule

`default_nettype wire

//--- hw/capture_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module capture_buffer (
   input  wire                   fe_clk,
   input  wire                   arst_n_i,
   input  wire                   clear_i,
   input  wire                   fire_i,
   input  wire                   write_i,
   input  wire pw_pkg::byte_t    data_i,
   input  wire                   pop_i,
   output pw_pkg::entry_t        head_o,
   output logic                  empty_o,
   output logic                  overflow_o
);
   import pw_pkg::*;

   stamp_t    stamp_q;
   entry_t    mem [FIFO_DEPTH];
   fifo_ptr_t wr_ptr_q, rd_ptr_q;
   logic [$clog2(FIFO_DEPTH):0] fill_q;
   logic      full, push, pop;

   assign full    = (fill_q == FIFO_DEPTH);
   assign empty_o = (fill_q == '0);
   assign push    = write_i && !full;
   assign pop     = pop_i && !empty_o;
   assign head_o  = mem[rd_ptr_q];

   //////////////////////////////
   // inter-byte timestamp
   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i)
         stamp_q <= '0;
      else if (fire_i || write_i)
         stamp_q <= '0;
      else if (stamp_q != '1)
         stamp_q <= stamp_q + 8'd1;  // stick at 255
   end

   //////////////////////////////
   // circular fifo
   always_ff @(posedge fe_clk) begin
      if (push && !clear_i) mem[wr_ptr_q] <= {stamp_q, data_i};
   end

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         fill_q     <= '0;
         overflow_o <= 1'b0;
      end else if (clear_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         fill_q     <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 4'd1;
         if (pop) rd_ptr_q <= rd_ptr_q + 4'd1;
         fill_q <= fill_q + {4'd0, push} - {4'd0, pop};
         if (write_i && full) overflow_o <= 1'b1;  // byte dropped
      end
   end

endmodule

`default_nettype wire

//--- hw/pw_sniffer_top.sv
`default_nettype none
`timescale 1ns/1ps

module pw_sniffer_top (
   input  wire                   fe_clk,
   input  wire                   arst_n_i,
   input  wire pw_pkg::byte_t    fe_data_i,
   input  wire                   fe_rxvalid_i,
   input  wire pw_pkg::addr_t    reg_addr_i,
   input  wire pw_pkg::byte_t    reg_wdata_i,
   input  wire                   reg_write_i,
   input  wire                   reg_read_i,
   output pw_pkg::entry_t        reg_rdata_o,
   output logic [1:0]            fe_xcvrsel_o,
   output logic                  fe_termsel_o,
   output logic                  cw_trig_o,
   output logic                  armed_o,      // LED_CAP
   output logic                  capturing_o,  // LED_TRIG
   output logic                  fifo_empty_o,
   output logic                  fifo_overflow_o
);
   import pw_pkg::*;

   pattern_t pattern, mask;
   count_t   delay, width, capture_len;
   speed_t   speed;
   entry_t   fifo_head;
   logic     arm_req, fifo_pop, match, fire, fifo_write;

   pw_regs U_regs (
      .fe_clk        (fe_clk),
      .arst_n_i      (arst_n_i),
      .reg_addr_i    (reg_addr_i),
      .reg_wdata_i   (reg_wdata_i),
      .reg_write_i   (reg_write_i),
      .reg_read_i    (reg_read_i),
      .fifo_head_i   (fifo_head),
      .fifo_empty_i  (fifo_empty_o),
      .reg_rdata_o   (reg_rdata_o),
      .pattern_o     (pattern),
      .mask_o        (mask),
      .delay_o       (delay),
      .width_o       (width),
      .capture_len_o (capture_len),
      .speed_o       (speed),
      .arm_req_o     (arm_req),
      .fifo_pop_o    (fifo_pop)
   );

   capture_ctrl U_ctrl (
      .fe_clk        (fe_clk),
      .arst_n_i      (arst_n_i),
      .arm_req_i     (arm_req),
      .match_i       (match),
      .fe_rxvalid_i  (fe_rxvalid_i),
      .capture_len_i (capture_len),
      .fire_o        (fire),
      .fifo_write_o  (fifo_write),
      .armed_o       (armed_o),
      .capturing_o   (capturing_o)
   );

   pattern_matcher U_matcher (
      .fe_clk       (fe_clk),
      .arst_n_i     (arst_n_i),
      .fe_data_i    (fe_data_i),
      .fe_rxvalid_i (fe_rxvalid_i),
      .pattern_i    (pattern),
      .mask_i       (mask),
      .match_o      (match)
   );

   trigger_pulse U_trigger (
      .fe_clk   (fe_clk),
      .arst_n_i (arst_n_i),
      .fire_i   (fire),
      .delay_i  (delay),
      .width_i  (width),
      .trig_o   (cw_trig_o)
   );

   capture_buffer U_buffer (
      .fe_clk     (fe_clk),
      .arst_n_i   (arst_n_i),
      .clear_i    (arm_req),   // arming flushes old capture
      .fire_i     (fire),
      .write_i    (fifo_write),
      .data_i     (fe_data_i),
      .pop_i      (fifo_pop),
      .head_o     (fifo_head),
      .empty_o    (fifo_empty_o),
      .overflow_o (fifo_overflow_o)
   );

   //////////////////////////////
   // transceiver select from speed
   always_comb begin
      case (speed)
         LS: begin
            fe_xcvrsel_o = 2'b10;
            fe_termsel_o = 1'b1;
         end
         HS: begin
            fe_xcvrsel_o = 2'b00;
            fe_termsel_o = 1'b0;
         end
         default: begin          // FS, and AUTO falls back to FS
            fe_xcvrsel_o = 2'b01;
            fe_termsel_o = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;  // 100 ns period
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (3) @(posedge clk_o);
      arst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

//--- verification/pw_sniffer_checker.sv
`default_nettype none
`timescale 1ns/1ps

module pw_sniffer_checker (
   input wire                fe_clk,
   input wire                arst_n_i,
   input wire                reg_write_i,
   input wire pw_pkg::addr_t reg_addr_i,
   input wire pw_pkg::byte_t reg_wdata_i,
   input wire                cw_trig_o,
   input wire                armed_o,
   input wire                capturing_o,
   input wire                fifo_empty_o
);
   import pw_pkg::*;

   logic seen_capture_q;  // a capture has started since reset

   always_ff @(posedge fe_clk or negedge arst_n_i) begin
      if (!arst_n_i)
         seen_capture_q <= 1'b0;
      else if (capturing_o)
         seen_capture_q <= 1'b1;
   end

   // the two status leds are exclusive
   a_state_leds: assert property (@(posedge fe_clk) disable iff (!arst_n_i)
      !(armed_o && capturing_o))
      else $error("armed_o and capturing_o are high in the same cycle");

   a_trig_after_capture: assert property (@(posedge fe_clk) disable iff (!arst_n_i)
      cw_trig_o |-> (seen_capture_q || capturing_o))
      else $error("cw_trig_o rose before any capture had started");

   a_arm_flushes: assert property (@(posedge fe_clk) disable iff (!arst_n_i)
      (reg_write_i && reg_addr_i == ADDR_ARM && reg_wdata_i[0]) |=> fifo_empty_o)
      else $error("fifo not empty in the cycle after an arm write");

endmodule

bind pw_sniffer_top pw_sniffer_checker u_checker (
   .fe_clk       (fe_clk),
   .arst_n_i     (arst_n_i),
   .reg_write_i  (reg_write_i),
   .reg_addr_i   (reg_addr_i),
   .reg_wdata_i  (reg_wdata_i),
   .cw_trig_o    (cw_trig_o),
   .armed_o      (armed_o),
   .capturing_o  (capturing_o),
   .fifo_empty_o (fifo_empty_o)
);

`default_nettype wire

//--- verification/tb_pw_sniffer.sv
`default_nettype none
`timescale 1ns/1ps

module tb_pw_sniffer;
   import pw_pkg::*;

   logic       fe_clk, arst_n_i;
   byte_t      fe_data_i, reg_wdata_i;
   addr_t      reg_addr_i;
   logic       fe_rxvalid_i, reg_write_i, reg_read_i;
   entry_t     reg_rdata_o;
   logic [1:0] fe_xcvrsel_o;
   logic       fe_termsel_o, cw_trig_o, armed_o, capturing_o, fifo_empty_o, fifo_overflow_o;

   int mismatch_count = 0;
   int timeout_count  = 0;

   tb_clock_gen u_clock (.clk_o(fe_clk), .arst_n_o(arst_n_i));

   pw_sniffer_top dut (.*);

   //////////////////////////////
   // reference model
   ctrl_state_t m_state;
   count_t      m_count, m_len, m_delay, m_width, t_delay, t_width;
   pattern_t    m_pat, m_mask, m_win;
   logic        m_match, m_ovf, t_valid;
   logic [1:0]  m_speed;
   stamp_t      m_stamp;
   entry_t      m_fifo [$];
   longint      m_cycle, fire_cyc;

   task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
      assert (got === exp) else begin
         mismatch_count++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // checks outputs mid-cycle, then steps the model as the next edge would
   always @(negedge fe_clk) begin
      logic       arm, fire, wr, rd, full, exp_trig;
      logic [1:0] exp_sel;
      if (!arst_n_i) begin
         m_state = IDLE;
         {m_count, m_len, m_delay, m_width, t_delay, t_width} = '0;
         {m_pat, m_mask, m_win} = '0;
         {m_match, m_ovf, t_valid} = '0;
         m_speed = 2'd0;
         m_stamp = '0;
         m_fifo.delete();
         m_cycle = 0;
         fire_cyc = 0;
      end else begin
         arm  = reg_write_i && reg_addr_i == ADDR_ARM && reg_wdata_i[0];
         fire = m_state == ARMED && m_match && !arm;
         wr   = m_state == CAPTURE && fe_rxvalid_i && m_count < m_len;
         rd   = reg_read_i && reg_addr_i == ADDR_FIFO && m_fifo.size() > 0;
         full = m_fifo.size() == FIFO_DEPTH;
         exp_trig = t_valid && m_cycle >= fire_cyc + t_delay + 1
                    && m_cycle < fire_cyc + t_delay + 1 + t_width;
         exp_sel = (m_speed == 2'd0) ? 2'b10 : (m_speed == 2'd2) ? 2'b00 : 2'b01;

         check_value(armed_o, m_state == ARMED, "armed_o");
         check_value(capturing_o, m_state == CAPTURE, "capturing_o");
         check_value(cw_trig_o, exp_trig, "cw_trig_o");
         check_value(fifo_empty_o, m_fifo.size() == 0, "fifo_empty_o");
         check_value(fifo_overflow_o, m_ovf, "fifo_overflow_o");
         check_value(reg_rdata_o, rd ? m_fifo[0] : 16'h0000, "reg_rdata_o");
         check_value(fe_xcvrsel_o, exp_sel, "fe_xcvrsel_o");
         check_value(fe_termsel_o, m_speed != 2'd2, "fe_termsel_o");

         m_match = 1'b0;
         if (fe_rxvalid_i) begin
            m_win   = {m_win[23:0], fe_data_i};
            m_match = ((m_win ^ m_pat) & m_mask) == '0;
         end

         if (arm) begin
            m_state = ARMED;
            m_count = '0;
         end else if (fire) begin
            m_state = CAPTURE;
         end else if (m_state == CAPTURE) begin
            if (m_len == '0) begin
               m_state = IDLE;
            end else if (wr) begin
               m_count++;
               if (m_count == m_len) m_state = IDLE;
            end
         end

         if (arm) begin
            m_fifo.delete();
            m_ovf = 1'b0;
         end else begin
            if (wr && full) m_ovf = 1'b1;  // byte lost
            if (rd) void'(m_fifo.pop_front());
            if (wr && !full) m_fifo.push_back({m_stamp, fe_data_i});
         end
         if (fire || wr) m_stamp = '0;
         else if (m_stamp != 8'hFF) m_stamp++;

         if (fire) begin
            t_valid  = 1'b1;
            fire_cyc = m_cycle;
            t_delay  = m_delay;
            t_width  = m_width;
         end

         if (reg_write_i) begin
            case (reg_addr_i)
               8'h01: m_speed = reg_wdata_i[1:0];
               8'h02, 8'h03, 8'h04, 8'h05: m_pat[8*(reg_addr_i - 8'h02) +: 8] = reg_wdata_i;
               8'h06, 8'h07, 8'h08, 8'h09: m_mask[8*(reg_addr_i - 8'h06) +: 8] = reg_wdata_i;
               8'h0A: m_delay[7:0]  = reg_wdata_i;
               8'h0B: m_delay[15:8] = reg_wdata_i;
               8'h0C: m_width[7:0]  = reg_wdata_i;
               8'h0D: m_width[15:8] = reg_wdata_i;
               8'h0E: m_len[7:0]    = reg_wdata_i;
               8'h0F: m_len[15:8]   = reg_wdata_i;
               default: ;
            endcase
         end
         m_cycle++;
      end
   end

   //////////////////////////////
   // stimulus
   task automatic drive(input logic valid, input byte_t data, input logic wr, input logic rd,
                        input addr_t addr, input byte_t wdata);
      @(posedge fe_clk);
      fe_rxvalid_i <= valid;
      fe_data_i    <= data;
      reg_write_i  <= wr;
      reg_read_i   <= rd;
      reg_addr_i   <= addr;
      reg_wdata_i  <= wdata;
   endtask

   task automatic idle_cycle();
      drive(1'b0, '0, 1'b0, 1'b0, '0, '0);
   endtask

   task automatic write_reg(input addr_t addr, input byte_t data);
      drive(1'b0, '0, 1'b1, 1'b0, addr, data);
   endtask

   task automatic configure(input pattern_t pat, input pattern_t mask, input count_t dly,
                            input count_t wid, input count_t len);
      for (int i = 0; i < PATTERN_BYTES; i++) begin
         write_reg(ADDR_PATTERN + addr_t'(i), pat[8*i +: 8]);
         write_reg(ADDR_MASK + addr_t'(i), mask[8*i +: 8]);
      end
      write_reg(ADDR_DELAY, dly[7:0]);
      write_reg(ADDR_DELAY + 8'd1, dly[15:8]);
      write_reg(ADDR_WIDTH, wid[7:0]);
      write_reg(ADDR_WIDTH + 8'd1, wid[15:8]);
      write_reg(ADDR_LEN, len[7:0]);
      write_reg(ADDR_LEN + 8'd1, len[15:8]);
   endtask

   // oldest byte first, gaps do not shift the window
   task automatic send_pattern(input pattern_t pat);
      for (int i = PATTERN_BYTES - 1; i >= 0; i--) begin
         if ($urandom_range(0, 2) == 0) idle_cycle();
         drive(1'b1, pat[8*i +: 8], 1'b0, 1'b0, '0, '0);
      end
   endtask

   task automatic stream_until_done(input int max_cycles);
      int n;
      n = 0;
      do begin
         drive($urandom_range(0, 9) < 7, byte_t'($urandom), 1'b0, 1'b0, '0, '0);
         @(negedge fe_clk);
         n++;
      end while ((armed_o || capturing_o) && n < max_cycles);
      if (armed_o || capturing_o) begin
         timeout_count++;
         $display("timeout: capture did not finish within %0d cycles", max_cycles);
      end
   endtask

   task automatic read_fifo(input int max_reads, output int reads);
      reads = 0;
      @(negedge fe_clk);
      while (!fifo_empty_o && reads < max_reads) begin
         drive(1'b0, '0, 1'b0, 1'b1, ADDR_FIFO, '0);
         idle_cycle();
         @(negedge fe_clk);
         reads++;
      end
   endtask

   initial begin
      int unsigned seed;
      int          n;
      pattern_t    pat, mask;
      count_t      dly, wid, len;
      fe_data_i    = '0;
      fe_rxvalid_i = 1'b0;
      reg_addr_i   = '0;
      reg_wdata_i  = '0;
      reg_write_i  = 1'b0;
      reg_read_i   = 1'b0;
      seed = $urandom(32'hddd6_a151);

      n = 0;
      @(negedge fe_clk);
      while (!arst_n_i && n < 20) begin
         @(negedge fe_clk);
         n++;
      end
      if (!arst_n_i) begin
         timeout_count++;
         $display("timeout: reset was never released");
      end

      for (int s = 0; s < 4; s++) begin   // transceiver decode
         write_reg(ADDR_SPEED, byte_t'(s));
         idle_cycle();
      end

      for (int it = 0; it < 12; it++) begin
         pat  = $urandom;
         mask = $urandom;
         dly  = count_t'($urandom_range(0, 12));
         wid  = count_t'($urandom_range(0, 6));
         len  = count_t'($urandom_range(0, FIFO_DEPTH));
         configure(pat, mask, dly, wid, len);
         send_pattern(pat);   // idle, must not capture
         idle_cycle();
         write_reg(ADDR_ARM, 8'h01);
         repeat ($urandom_range(0, 8)) drive(1'b1, byte_t'($urandom), 1'b0, 1'b0, '0, '0);
         send_pattern(pat);
         stream_until_done(200);
         repeat (dly + wid + 2) idle_cycle();
         read_fifo(FIFO_DEPTH + 4, n);
         check_value(16'(n), len, "number of fifo entries read");
      end

      //////////////////////////////
      // overflow, then flush by a new arm
      configure(pat, mask, dly, wid, count_t'($urandom_range(20, 40)));
      write_reg(ADDR_ARM, 8'h01);
      send_pattern(pat);
      repeat (300) idle_cycle();   // quiet line, stamp runs into its limit
      stream_until_done(300);
      repeat (dly + wid + 2) idle_cycle();
      @(negedge fe_clk);
      check_value(fifo_overflow_o, 1'b1, "fifo_overflow_o after long capture");
      read_fifo(4, n);     // oldest entries survive
      write_reg(ADDR_ARM, 8'h01);
      idle_cycle();
      @(negedge fe_clk);
      check_value(fifo_empty_o, 1'b1, "fifo_empty_o after re-arm");
      check_value(fifo_overflow_o, 1'b0, "fifo_overflow_o after re-arm");

      $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
hw/pw_pkg.sv
hw/pw_regs.sv
hw/capture_ctrl.sv
hw/pattern_matcher.sv
hw/trigger_pulse.sv
hw/capture_buffer.sv
hw/pw_sniffer_top.sv
verification/tb_clock_gen.sv
verification/pw_sniffer_checker.sv
verification/tb_pw_sniffer.sv

//--- Makefile
TOP = tb_pw_sniffer

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q ">>> FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
